// File: Makefile
# Verilator flow for the cortical column testbench

VERILATOR ?= verilator
TOP       ?= tb_cortical_column
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+rtl
+incdir+verif
rtl/fixed_pkg.sv
rtl/column_pkg.sv
rtl/column_state_if.sv
rtl/hopf_oscillator.sv
rtl/pv_interneuron.sv
rtl/pv_network.sv
rtl/laminar_drive.sv
rtl/cortical_column.sv
verif/tb_cortical_column.sv

// File: rtl/col_cfg.svh
`ifndef COL_CFG_SVH
`define COL_CFG_SVH

// ==============================
// Fixed point format
// ==============================

// Q4.14 sample
`define COL_WIDTH 18
`define COL_FRAC 14

// ==============================
// Layer frequencies
// ==============================

// Angular step per update at the 4 kHz step rate
`define COL_OMEGA_L4 18'sd817
`define COL_OMEGA_L23_SLOW 18'sd1039
`define COL_OMEGA_L23_FAST 18'sd1681
`define COL_OMEGA_L5B 18'sd642
`define COL_OMEGA_L6 18'sd245

// Inter-layer coupling gains in Q4.14
`define COL_K_L4_L23 18'sd6554
`define COL_K_L23_L5 18'sd4915
`define COL_K_L5_L6 18'sd3277
`define COL_K_PAC 18'sd3277
`define COL_K_FB 18'sd3277

// Cubic radius term scaled down by the time step
`define COL_CUBIC_SHIFT 4

// PV+ integrator leak and output gain (0.5)
`define COL_PV_TAU_SHIFT 3
`define COL_K_PV 18'sd8192

`endif

// File: rtl/column_pkg.sv
`default_nettype none

package column_pkg;

    // One oscillator state
    // x is the observable output, y the quadrature part
    typedef struct packed {
        fixed_pkg::sample_t x;
        fixed_pkg::sample_t y;
    } osc_state_t;

    // Input drive for each of the four oscillators
    typedef struct packed {
        fixed_pkg::sample_t l4;
        fixed_pkg::sample_t l23;
        fixed_pkg::sample_t l5b;
        fixed_pkg::sample_t l6;
    } layer_drive_t;

endpackage

`default_nettype wire

// File: rtl/column_state_if.sv
`timescale 1ns/1ps
`default_nettype none

interface column_state_if;

    // Registered state of each layer oscillator
    column_pkg::osc_state_t l4;
    column_pkg::osc_state_t l23;
    column_pkg::osc_state_t l5b;
    column_pkg::osc_state_t l6;

    // Oscillator side
    modport writer (
        output l4,
        output l23,
        output l5b,
        output l6
    );

    // Drive network and PV+ side
    modport reader (
        input l4,
        input l23,
        input l5b,
        input l6
    );

endinterface

`default_nettype wire

// File: rtl/cortical_column.sv
`timescale 1ns/1ps
`default_nettype none

`include "col_cfg.svh"

module cortical_column (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               clk_en,
    input  wire fixed_pkg::sample_t thalamic_theta_input,
    input  wire fixed_pkg::sample_t feedforward_input,
    input  wire fixed_pkg::sample_t feedback_input,
    input  wire fixed_pkg::sample_t phase_couple_l23,
    input  wire fixed_pkg::sample_t phase_couple_l6,
    input  wire fixed_pkg::sample_t mu_dt_l4,
    input  wire fixed_pkg::sample_t mu_dt_l23,
    input  wire fixed_pkg::sample_t mu_dt_l5b,
    input  wire fixed_pkg::sample_t mu_dt_l6,
    input  wire logic               encoding_window,
    output fixed_pkg::sample_t      l4_x,
    output fixed_pkg::sample_t      l23_x,
    output fixed_pkg::sample_t      l23_y,
    output fixed_pkg::sample_t      l5b_x,
    output fixed_pkg::sample_t      l6_x,
    output fixed_pkg::sample_t      l6_y
);

    column_pkg::layer_drive_t drive;
    fixed_pkg::sample_t       omega_l23;
    fixed_pkg::sample_t       pv_total;

    // Shared state of the four layers
    column_state_if col_if ();

    // ==============================
    // Drive network and PV+ cells
    // ==============================
    laminar_drive u_drive (
        .col                  (col_if.reader),
        .pv_total             (pv_total),
        .thalamic_theta_input (thalamic_theta_input),
        .feedforward_input    (feedforward_input),
        .feedback_input       (feedback_input),
        .phase_couple_l23     (phase_couple_l23),
        .phase_couple_l6      (phase_couple_l6),
        .encoding_window      (encoding_window),
        .drive                (drive),
        .omega_l23            (omega_l23)
    );

    pv_network u_pv (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .col      (col_if.reader),
        .pv_total (pv_total)
    );

    // Layer oscillators
    hopf_oscillator osc_l4 (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
        .mu_dt (mu_dt_l4), .omega_dt (`COL_OMEGA_L4),
        .input_x (drive.l4), .state (col_if.l4)
    );

    // L2/3 frequency follows the encoding window
    hopf_oscillator osc_l23 (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
        .mu_dt (mu_dt_l23), .omega_dt (omega_l23),
        .input_x (drive.l23), .state (col_if.l23)
    );

    hopf_oscillator osc_l5b (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
        .mu_dt (mu_dt_l5b), .omega_dt (`COL_OMEGA_L5B),
        .input_x (drive.l5b), .state (col_if.l5b)
    );

    hopf_oscillator osc_l6 (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
        .mu_dt (mu_dt_l6), .omega_dt (`COL_OMEGA_L6),
        .input_x (drive.l6), .state (col_if.l6)
    );

    assign l4_x  = col_if.l4.x;
    assign l23_x = col_if.l23.x;
    assign l23_y = col_if.l23.y;
    assign l5b_x = col_if.l5b.x;
    assign l6_x  = col_if.l6.x;
    assign l6_y  = col_if.l6.y;

endmodule

`default_nettype wire

// File: rtl/fixed_pkg.sv
`default_nettype none

`include "col_cfg.svh"

package fixed_pkg;

    // Signed Q4.14 sample shared by every layer
    typedef logic signed [`COL_WIDTH-1:0] sample_t;

    // Full width product of two samples
    typedef logic signed [2*`COL_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

// File: rtl/hopf_oscillator.sv
`timescale 1ns/1ps
`default_nettype none

`include "col_cfg.svh"

module hopf_oscillator (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               clk_en,
    input  wire fixed_pkg::sample_t mu_dt,
    input  wire fixed_pkg::sample_t omega_dt,
    input  wire fixed_pkg::sample_t input_x,
    output column_pkg::osc_state_t  state
);

    fixed_pkg::sample_t x_q;
    fixed_pkg::sample_t y_q;

    // Full products
    fixed_pkg::product_t p_xx, p_yy, r2_full;
    fixed_pkg::product_t p_mx, p_my, p_wx, p_wy, p_rx, p_ry;

    // Scaled terms back in Q4.14
    fixed_pkg::sample_t r2;
    fixed_pkg::sample_t t_mx, t_my, t_wx, t_wy, t_rx, t_ry;
    fixed_pkg::sample_t x_next, y_next;

    // ==============================
    // Radius squared
    // ==============================
    assign p_xx    = x_q * x_q;
    assign p_yy    = y_q * y_q;
    assign r2_full = p_xx + p_yy;
    // Cubic term already multiplied by dt
    assign r2 = fixed_pkg::sample_t'((r2_full >>> `COL_FRAC) >>> `COL_CUBIC_SHIFT);

    // Growth, rotation and saturation products
    assign p_mx = mu_dt * x_q;
    assign p_my = mu_dt * y_q;
    assign p_wx = omega_dt * x_q;
    assign p_wy = omega_dt * y_q;
    assign p_rx = r2 * x_q;
    assign p_ry = r2 * y_q;

    assign t_mx = fixed_pkg::sample_t'(p_mx >>> `COL_FRAC);
    assign t_my = fixed_pkg::sample_t'(p_my >>> `COL_FRAC);
    assign t_wx = fixed_pkg::sample_t'(p_wx >>> `COL_FRAC);
    assign t_wy = fixed_pkg::sample_t'(p_wy >>> `COL_FRAC);
    assign t_rx = fixed_pkg::sample_t'(p_rx >>> `COL_FRAC);
    assign t_ry = fixed_pkg::sample_t'(p_ry >>> `COL_FRAC);

    // Euler step, sums wrap at the sample width
    assign x_next = x_q + t_mx - t_wy - t_rx + input_x;
    assign y_next = y_q + t_my + t_wx - t_ry;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (clk_en) begin
            x_q <= x_next;
            y_q <= y_next;
        end
    end

    assign state.x = x_q;
    assign state.y = y_q;

endmodule

`default_nettype wire

// File: rtl/laminar_drive.sv
`timescale 1ns/1ps
`default_nettype none

`include "col_cfg.svh"

module laminar_drive (
    column_state_if.reader          col,
    input  wire fixed_pkg::sample_t pv_total,
    input  wire fixed_pkg::sample_t thalamic_theta_input,
    input  wire fixed_pkg::sample_t feedforward_input,
    input  wire fixed_pkg::sample_t feedback_input,
    input  wire fixed_pkg::sample_t phase_couple_l23,
    input  wire fixed_pkg::sample_t phase_couple_l6,
    input  wire logic               encoding_window,
    output column_pkg::layer_drive_t drive,
    output fixed_pkg::sample_t      omega_l23
);

    // Coupling products at full width
    fixed_pkg::product_t p_l4_l23;
    fixed_pkg::product_t p_pac;
    fixed_pkg::product_t p_l23_l5;
    fixed_pkg::product_t p_l5_l6;
    fixed_pkg::product_t p_fb;

    // Same products in Q4.14
    fixed_pkg::sample_t c_l4_l23;
    fixed_pkg::sample_t c_pac;
    fixed_pkg::sample_t c_l23_l5;
    fixed_pkg::sample_t c_l5_l6;
    fixed_pkg::sample_t c_fb;

    assign p_l4_l23 = `COL_K_L4_L23 * col.l4.x;
    // PAC from the L6 alpha quadrature
    assign p_pac    = `COL_K_PAC * col.l6.y;
    assign p_l23_l5 = `COL_K_L23_L5 * col.l23.x;
    assign p_l5_l6  = `COL_K_L5_L6 * col.l5b.x;
    // Inter-column feedback shared by L5b and L6
    assign p_fb     = `COL_K_FB * feedback_input;

    assign c_l4_l23 = fixed_pkg::sample_t'(p_l4_l23 >>> `COL_FRAC);
    assign c_pac    = fixed_pkg::sample_t'(p_pac >>> `COL_FRAC);
    assign c_l23_l5 = fixed_pkg::sample_t'(p_l23_l5 >>> `COL_FRAC);
    assign c_l5_l6  = fixed_pkg::sample_t'(p_l5_l6 >>> `COL_FRAC);
    assign c_fb     = fixed_pkg::sample_t'(p_fb >>> `COL_FRAC);

    // ==============================
    // Canonical microcircuit drive
    // ==============================

    // Thalamus into L4
    assign drive.l4 = thalamic_theta_input + feedforward_input;

    // L4 feedforward plus PAC plus phase coupling, minus PV+ inhibition
    assign drive.l23 = c_l4_l23 + c_pac + phase_couple_l23 - pv_total;

    // L2/3 output into L5b
    assign drive.l5b = c_l23_l5 + c_fb;

    // L5b into L6 with phase coupling
    assign drive.l6 = c_l5_l6 + c_fb + phase_couple_l6;

    // Gamma nesting
    // fast gamma while encoding, slow gamma during retrieval
    assign omega_l23 = encoding_window ? `COL_OMEGA_L23_FAST : `COL_OMEGA_L23_SLOW;

endmodule

`default_nettype wire

// File: rtl/pv_interneuron.sv
`timescale 1ns/1ps
`default_nettype none

`include "col_cfg.svh"

module pv_interneuron (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               clk_en,
    input  wire fixed_pkg::sample_t pyramid_input,
    output fixed_pkg::sample_t      inhibition
);

    fixed_pkg::sample_t  pv_q;
    fixed_pkg::sample_t  rect;
    fixed_pkg::sample_t  diff;
    fixed_pkg::product_t p_inh;

    // Only excitation drives the basket cell
    assign rect = (pyramid_input < 0) ? '0 : pyramid_input;

    // Leak toward the rectified input
    assign diff = rect - pv_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pv_q <= '0;
        end else if (clk_en) begin
            pv_q <= pv_q + (diff >>> `COL_PV_TAU_SHIFT);
        end
    end

    // Output gain
    assign p_inh      = pv_q * `COL_K_PV;
    assign inhibition = fixed_pkg::sample_t'(p_inh >>> `COL_FRAC);

endmodule

`default_nettype wire

// File: rtl/pv_network.sv
`timescale 1ns/1ps
`default_nettype none

module pv_network (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          clk_en,
    column_state_if.reader     col,
    output fixed_pkg::sample_t pv_total
);

    fixed_pkg::sample_t inh_l23;
    fixed_pkg::sample_t inh_l4;
    fixed_pkg::sample_t inh_l5b;

    // Local PING population in L2/3
    pv_interneuron pv_l23 (
        .clk           (clk),
        .rst_n         (rst_n),
        .clk_en        (clk_en),
        .pyramid_input (col.l23.x),
        .inhibition    (inh_l23)
    );

    // Feedforward gating from L4
    pv_interneuron pv_l4 (
        .clk           (clk),
        .rst_n         (rst_n),
        .clk_en        (clk_en),
        .pyramid_input (col.l4.x),
        .inhibition    (inh_l4)
    );

    // Feedback inhibition from L5b
    pv_interneuron pv_l5b (
        .clk           (clk),
        .rst_n         (rst_n),
        .clk_en        (clk_en),
        .pyramid_input (col.l5b.x),
        .inhibition    (inh_l5b)
    );

    // Weights 1, 1/2 and 1/4
    assign pv_total = inh_l23 + (inh_l4 >>> 1) + (inh_l5b >>> 2);

endmodule

`default_nettype wire

// File: verif/column_patterns.mem
// count en enc thal ff fb pc_l23 pc_l6 mu_l4 mu_l23 mu_l5b mu_l6, all hex
// en 0 holds, 1 steps, 2 random strobe; a zero count ends the list
// Zero inputs stay at the fixed point
010 2 0 00000 00000 00000 00000 00000 000A4 000A4 000A4 000A4
// Thalamic and feedforward kick into L4
004 1 0 01000 00800 00000 00000 00000 000A4 000A4 000A4 000A4
// Free run, activity moves down the column
030 1 0 00000 00000 00000 00000 00000 000A4 000A4 000A4 000A4
// Strobe low, inputs change, outputs hold
008 0 1 02000 3F000 01000 00800 3F800 00100 00100 00100 00100
// Encoding window, fast gamma in L2/3
020 1 1 00000 00000 00000 00000 00000 000A4 000A4 000A4 000A4
// Retrieval, slow gamma, random strobe
040 2 0 00400 00000 00000 00000 00000 000A4 000A4 000A4 000A4
// Strong L4 drive builds PV+ inhibition on L2/3
030 1 0 02000 01000 00000 00000 00000 00148 00148 00148 00148
// Feedback and phase coupling into L2/3, L5b, L6
030 2 1 00000 00000 00800 00400 3FC00 000A4 000A4 000A4 000A4
// Negative drive, PV+ rectification
020 1 0 3E000 3F000 3F800 00000 00000 000A4 000A4 000A4 000A4
000 0 0 00000 00000 00000 00000 00000 00000 00000 00000 00000

// File: verif/column_model.svh
`ifndef COLUMN_MODEL_SVH
`define COLUMN_MODEL_SVH

`include "col_cfg.svh"

// ==============================
// Column reference model
// ==============================

// Oscillator state, index 0..3 is L4, L2/3, L5b, L6
longint m_x [4];
longint m_y [4];
// PV+ integrators on L2/3, L4 and L5b
longint m_pv [3];

// Keep the low sample bits, sign extended
function automatic longint wrap_sample(input longint v);
    fixed_pkg::sample_t s;
    s = fixed_pkg::sample_t'(v);
    return longint'(s);
endfunction

// Q4.14 product brought back to sample scale
function automatic longint scaled_product(input longint a, input longint b);
    return wrap_sample((a * b) >>> `COL_FRAC);
endfunction

task automatic reset_model();
    for (int i = 0; i < 4; i++) begin
        m_x[i] = 0;
        m_y[i] = 0;
    end
    for (int j = 0; j < 3; j++) begin
        m_pv[j] = 0;
    end
endtask

// One whole-column step from the state before the edge
task automatic step_model(
    input longint thal,
    input longint ff,
    input longint fb,
    input longint pc23,
    input longint pc6,
    input logic   enc,
    input longint mu_l4,
    input longint mu_l23,
    input longint mu_l5b,
    input longint mu_l6
);
    longint drv [4];
    longint omg [4];
    longint mu [4];
    longint nx [4];
    longint ny [4];
    longint inh [3];
    longint src [3];
    longint pv_sum;
    longint r2;
    longint rect;
    longint diff;
    // Weighted PV+ sum, weights 1, 1/2, 1/4
    for (int j = 0; j < 3; j++) begin
        inh[j] = scaled_product(m_pv[j], `COL_K_PV);
    end
    pv_sum = wrap_sample(inh[0] + (inh[1] >>> 1) + (inh[2] >>> 2));
    // Laminar drives
    drv[0] = wrap_sample(thal + ff);
    drv[1] = wrap_sample(scaled_product(`COL_K_L4_L23, m_x[0])
        + scaled_product(`COL_K_PAC, m_y[3]) + pc23 - pv_sum);
    drv[2] = wrap_sample(scaled_product(`COL_K_L23_L5, m_x[1])
        + scaled_product(`COL_K_FB, fb));
    drv[3] = wrap_sample(scaled_product(`COL_K_L5_L6, m_x[2])
        + scaled_product(`COL_K_FB, fb) + pc6);
    omg[0] = `COL_OMEGA_L4;
    omg[1] = enc ? `COL_OMEGA_L23_FAST : `COL_OMEGA_L23_SLOW;
    omg[2] = `COL_OMEGA_L5B;
    omg[3] = `COL_OMEGA_L6;
    mu[0] = mu_l4;
    mu[1] = mu_l23;
    mu[2] = mu_l5b;
    mu[3] = mu_l6;
    // Hopf Euler step per layer
    for (int i = 0; i < 4; i++) begin
        r2 = wrap_sample(((m_x[i] * m_x[i] + m_y[i] * m_y[i]) >>> `COL_FRAC)
            >>> `COL_CUBIC_SHIFT);
        nx[i] = wrap_sample(m_x[i] + scaled_product(mu[i], m_x[i])
            - scaled_product(omg[i], m_y[i]) - scaled_product(r2, m_x[i]) + drv[i]);
        ny[i] = wrap_sample(m_y[i] + scaled_product(mu[i], m_y[i])
            + scaled_product(omg[i], m_x[i]) - scaled_product(r2, m_y[i]));
    end
    // PV+ leak toward the rectified pyramid output
    src[0] = m_x[1];
    src[1] = m_x[0];
    src[2] = m_x[2];
    for (int j = 0; j < 3; j++) begin
        rect = (src[j] < 0) ? 0 : src[j];
        diff = wrap_sample(rect - m_pv[j]);
        m_pv[j] = wrap_sample(m_pv[j] + (diff >>> `COL_PV_TAU_SHIFT));
    end
    for (int i = 0; i < 4; i++) begin
        m_x[i] = nx[i];
        m_y[i] = ny[i];
    end
endtask

`endif

// File: verif/tb_cortical_column.sv
`timescale 1ns/1ps
`default_nettype none

`include "col_cfg.svh"

module tb_cortical_column;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int ROW_WORDS    = 12;
    localparam int MAX_ROWS     = 32;

    logic clk;
    logic rst_n;
    logic clk_en;
    logic encoding_window;
    fixed_pkg::sample_t thalamic_theta_input, feedforward_input, feedback_input;
    fixed_pkg::sample_t phase_couple_l23, phase_couple_l6;
    fixed_pkg::sample_t mu_dt_l4, mu_dt_l23, mu_dt_l5b, mu_dt_l6;
    fixed_pkg::sample_t l4_x, l23_x, l23_y, l5b_x, l6_x, l6_y;

    // Twelve words per pattern row
    logic [`COL_WIDTH-1:0] pattern_mem [0:ROW_WORDS*MAX_ROWS-1];
    longint watchdog_ns = 0;

    `include "column_model.svh"

    cortical_column DUT (
        .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
        .thalamic_theta_input (thalamic_theta_input),
        .feedforward_input (feedforward_input), .feedback_input (feedback_input),
        .phase_couple_l23 (phase_couple_l23), .phase_couple_l6 (phase_couple_l6),
        .mu_dt_l4 (mu_dt_l4), .mu_dt_l23 (mu_dt_l23),
        .mu_dt_l5b (mu_dt_l5b), .mu_dt_l6 (mu_dt_l6),
        .encoding_window (encoding_window),
        .l4_x (l4_x), .l23_x (l23_x), .l23_y (l23_y),
        .l5b_x (l5b_x), .l6_x (l6_x), .l6_y (l6_y)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Unknown bits in an output count as a mismatch
    task automatic check_value(input string name, input logic signed [63:0] got,
                               input longint exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic compare_outputs();
        check_value("l4_x", l4_x, m_x[0]);
        check_value("l23_x", l23_x, m_x[1]);
        check_value("l23_y", l23_y, m_y[1]);
        check_value("l5b_x", l5b_x, m_x[2]);
        check_value("l6_x", l6_x, m_x[3]);
        check_value("l6_y", l6_y, m_y[3]);
    endtask

    // Strobe code 2 means a random strobe
    task automatic apply_row(input int base);
        logic [`COL_WIDTH-1:0] en_code;
        en_code = pattern_mem[base + 1];
        if (en_code == 2)
            clk_en = 1'($urandom_range(1, 0));
        else
            clk_en = en_code[0];
        encoding_window      = pattern_mem[base + 2][0];
        thalamic_theta_input = pattern_mem[base + 3];
        feedforward_input    = pattern_mem[base + 4];
        feedback_input       = pattern_mem[base + 5];
        phase_couple_l23     = pattern_mem[base + 6];
        phase_couple_l6      = pattern_mem[base + 7];
        mu_dt_l4             = pattern_mem[base + 8];
        mu_dt_l23            = pattern_mem[base + 9];
        mu_dt_l5b            = pattern_mem[base + 10];
        mu_dt_l6             = pattern_mem[base + 11];
    endtask

    // ==============================
    // Stimulus and checking
    // ==============================
    initial begin : stimulus
        int row;
        int base;
        longint total_cycles;
        void'($urandom(32'h1965_605e));
        clk = 1'b0;
        rst_n = 1'b0;
        foreach (pattern_mem[i]) pattern_mem[i] = '0;
        apply_row(0);
        reset_model();
        $readmemh("verif/column_patterns.mem", pattern_mem);
        // Count stops at the first row with a zero repeat count
        total_cycles = 0;
        for (row = 0; row < MAX_ROWS; row++) begin
            base = row * ROW_WORDS;
            if (pattern_mem[base] == 0)
                break;
            total_cycles += longint'(pattern_mem[base]);
        end
        if (total_cycles == 0) begin
            $display("No stimulus rows were loaded from the pattern file");
            $display("Test failed");
            $fatal(1, "empty stimulus");
        end
        watchdog_ns = (total_cycles + RESET_CYCLES + 100) * CLK_PERIOD;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (row = 0; row < MAX_ROWS; row++) begin
            base = row * ROW_WORDS;
            if (pattern_mem[base] == 0)
                break;
            repeat (int'(pattern_mem[base])) begin
                @(negedge clk);
                // Outputs are settled half a cycle after the rising edge
                compare_outputs();
                apply_row(base);
                if (clk_en)
                    step_model(longint'(thalamic_theta_input), longint'(feedforward_input),
                        longint'(feedback_input), longint'(phase_couple_l23),
                        longint'(phase_couple_l6), encoding_window,
                        longint'(mu_dt_l4), longint'(mu_dt_l23),
                        longint'(mu_dt_l5b), longint'(mu_dt_l6));
            end
        end
        @(negedge clk);
        compare_outputs();
        $display("Test passed");
        $finish;
    end

    // Limit set once the pattern length is known
    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Run timed out after %0d ns without finishing the patterns", watchdog_ns);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
